//--- logic/tex_cache_pkg.sv
// ------------------------------------------------------------
// texture cache tag stage, shared definitions
// coordinate widths, block geometry and the controller modes
// ------------------------------------------------------------

`default_nettype none

package tex_cache_pkg;

	// ------------------------------------------------------------
	// texel address space

	localparam int ADDR_X_WIDTH = 12;
	localparam int ADDR_Y_WIDTH = 12;

	// ------------------------------------------------------------
	// block geometry, log2 of pixels per block side

	localparam int BLK_X_SIZE = 2;
	localparam int BLK_Y_SIZE = 2;

	// ------------------------------------------------------------
	// coordinate types

	// full texel coordinates
	typedef logic [ADDR_X_WIDTH-1:0] addr_x_t;
	typedef logic [ADDR_Y_WIDTH-1:0] addr_y_t;

	// pixel offset within a block
	typedef logic [BLK_X_SIZE-1:0] pix_x_t;
	typedef logic [BLK_Y_SIZE-1:0] pix_y_t;

	// block coordinate, upper address bits
	typedef logic [ADDR_X_WIDTH-BLK_X_SIZE-1:0] blk_x_t;
	typedef logic [ADDR_Y_WIDTH-BLK_Y_SIZE-1:0] blk_y_t;

	// pipeline controller
	typedef enum logic {
		MODE_LOOKUP = 1'b0,
		MODE_CLEAR  = 1'b1
	} tag_mode_t;

endpackage

`default_nettype wire

//--- logic/tag_result_if.sv
// ------------------------------------------------------------
// tag result channel
// one looked-up access, from the tag pipeline to the output buffer
// ------------------------------------------------------------

`default_nettype none

interface tag_result_if #(
	parameter int TAG_ADDR_WIDTH = 6,
	parameter int USER_WIDTH     = 4
);
	import tex_cache_pkg::*;

	logic [USER_WIDTH-1:0]     user;
	logic                      last;
	logic                      border;
	logic [TAG_ADDR_WIDTH-1:0] tag_addr;
	pix_x_t                    pix_x;
	pix_y_t                    pix_y;
	blk_x_t                    blk_x;
	blk_y_t                    blk_y;
	logic                      hit;
	logic                      valid;
	logic                      ready;

	modport source (output user, last, border, tag_addr, pix_x, pix_y, blk_x, blk_y,
		hit, valid, input ready);
	modport sink (input user, last, border, tag_addr, pix_x, pix_y, blk_x, blk_y,
		hit, valid, output ready);

endinterface

`default_nettype wire

//--- logic/tag_index_map.sv
// ------------------------------------------------------------
// tag index map
// folds a block coordinate into a direct-mapped tag index
// ------------------------------------------------------------

`default_nettype none

module tag_index_map #(
	parameter int TAG_ADDR_WIDTH = 6
) (
	input  tex_cache_pkg::blk_x_t    blk_x,
	input  tex_cache_pkg::blk_y_t    blk_y,
	output logic [TAG_ADDR_WIDTH-1:0] tag_addr
);

	// half of the index comes from each axis
	localparam int HALF = TAG_ADDR_WIDTH / 2;

	logic [HALF-1:0] idx_x;
	logic [HALF-1:0] idx_y;
	logic [HALF-1:0] idx_skew;

	assign idx_x    = blk_x[HALF-1:0];
	assign idx_y    = blk_y[HALF-1:0];

	// next x bits skew the row part, so that
	// neighbouring block rows land on different entries
	assign idx_skew = blk_x[2*HALF-1:HALF];

	assign tag_addr = {idx_y ^ idx_skew, idx_x};

endmodule

`default_nettype wire

//--- logic/tag_ram.sv
// ------------------------------------------------------------
// tag memory
// single port, read-first, every entry starts out invalid
// ------------------------------------------------------------

`default_nettype none

module tag_ram #(
	parameter int ADDR_WIDTH = 6,
	parameter int DATA_WIDTH = 21
) (
	input  logic                  clk,
	input  logic                  en,
	input  logic                  we,
	input  logic [ADDR_WIDTH-1:0] addr,
	input  logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// all zero, valid bit clear
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
		rdata = '0;
	end

	// old contents come out even on a write
	always @(posedge clk) begin
		if (en) begin
			rdata <= mem[addr];
			if (we) begin
				mem[addr] <= wdata;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/tag_lookup_pipe.sv
// ------------------------------------------------------------
// tag lookup pipeline
// index, tag read/write, hit compare; also runs the clear sweep
// ------------------------------------------------------------

`default_nettype none

module tag_lookup_pipe #(
	parameter int TAG_ADDR_WIDTH = 6,
	parameter int USER_WIDTH     = 4
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    clear_start,
	output logic                    clear_busy,
	input  logic [USER_WIDTH-1:0]   s_user,
	input  logic                    s_last,
	input  logic                    s_border,
	input  tex_cache_pkg::addr_x_t  s_addrx,
	input  tex_cache_pkg::addr_y_t  s_addry,
	input  logic                    s_valid,
	output logic                    s_ready,
	tag_result_if.source            res
);
	import tex_cache_pkg::*;

	// valid flag above the stored block coordinate
	localparam int TAG_DATA_WIDTH = 1 + $bits(blk_y_t) + $bits(blk_x_t);

	tag_mode_t                 mode;
	logic [TAG_ADDR_WIDTH-1:0] clr_cnt;
	logic                      cke;
	blk_x_t                    s_blk_x;
	blk_y_t                    s_blk_y;
	logic [TAG_ADDR_WIDTH-1:0] s_tag_addr;
	logic                      st0_valid, st1_valid, st2_valid;
	logic [USER_WIDTH-1:0]     st0_user, st1_user;
	logic                      st0_last, st1_last, st0_border, st1_border;
	logic [TAG_ADDR_WIDTH-1:0] st0_tag_addr, st1_tag_addr;
	pix_x_t                    st0_pix_x, st1_pix_x;
	pix_y_t                    st0_pix_y, st1_pix_y;
	blk_x_t                    st0_blk_x, st1_blk_x;
	blk_y_t                    st0_blk_y, st1_blk_y;
	logic                      ram_we;
	logic [TAG_ADDR_WIDTH-1:0] ram_addr;
	logic [TAG_DATA_WIDTH-1:0] ram_wdata, ram_rdata;

	assign s_blk_x = s_addrx[ADDR_X_WIDTH-1:BLK_X_SIZE];
	assign s_blk_y = s_addry[ADDR_Y_WIDTH-1:BLK_Y_SIZE];

	tag_index_map #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH)) tag_index_map_i (
		.blk_x(s_blk_x), .blk_y(s_blk_y), .tag_addr(s_tag_addr));

	// whole pipe moves when st2 is empty or drained
	assign cke        = !st2_valid || res.ready;
	assign clear_busy = (mode == MODE_CLEAR);
	// no access is taken on the edge that starts a sweep
	assign s_ready    = cke && (mode == MODE_LOOKUP) && !clear_start;

	// ------------------------------------------------------------
	// tag port, the sweep owns it while clearing

	assign ram_we    = clear_busy || (st0_valid && !st0_border);
	assign ram_addr  = clear_busy ? clr_cnt : st0_tag_addr;
	assign ram_wdata = clear_busy ? '0 : {1'b1, st0_blk_y, st0_blk_x};

	tag_ram #(.ADDR_WIDTH(TAG_ADDR_WIDTH), .DATA_WIDTH(TAG_DATA_WIDTH)) tag_ram_i (
		.clk(clk), .en(cke), .we(ram_we), .addr(ram_addr),
		.wdata(ram_wdata), .rdata(ram_rdata));

	// ------------------------------------------------------------
	// mode and stage valids

	always_ff @(posedge clk) begin
		if (reset) begin
			mode      <= MODE_LOOKUP;
			clr_cnt   <= '0;
			st0_valid <= 1'b0;
			st1_valid <= 1'b0;
			st2_valid <= 1'b0;
		end else if (cke) begin
			st0_valid <= s_valid && s_ready;
			st1_valid <= st0_valid;
			st2_valid <= st1_valid;
			case (mode)
				MODE_LOOKUP: if (clear_start) begin
					mode    <= MODE_CLEAR;
					clr_cnt <= '0;
				end
				MODE_CLEAR: begin
					clr_cnt <= clr_cnt + 1'b1;
					if (clr_cnt == '1) mode <= MODE_LOOKUP;
				end
				default: mode <= MODE_LOOKUP;
			endcase
		end
	end

	// payload stages
	always_ff @(posedge clk) begin
		if (cke) begin
			{st0_user, st0_last, st0_border} <= {s_user, s_last, s_border};
			st0_tag_addr <= s_tag_addr;
			st0_pix_x    <= s_addrx[BLK_X_SIZE-1:0];
			st0_pix_y    <= s_addry[BLK_Y_SIZE-1:0];
			{st0_blk_y, st0_blk_x} <= {s_blk_y, s_blk_x};
			{st1_user, st1_last, st1_border} <= {st0_user, st0_last, st0_border};
			{st1_tag_addr, st1_pix_x, st1_pix_y} <= {st0_tag_addr, st0_pix_x, st0_pix_y};
			{st1_blk_y, st1_blk_x} <= {st0_blk_y, st0_blk_x};
			{res.user, res.last, res.border} <= {st1_user, st1_last, st1_border};
			{res.tag_addr, res.pix_x, res.pix_y} <= {st1_tag_addr, st1_pix_x, st1_pix_y};
			{res.blk_y, res.blk_x} <= {st1_blk_y, st1_blk_x};
			// hit: entry valid and same block
			res.hit <= ram_rdata[TAG_DATA_WIDTH-1]
				&& (ram_rdata[TAG_DATA_WIDTH-2:0] == {st1_blk_y, st1_blk_x});
		end
	end

	assign res.valid = st2_valid;

	// an access left in st0 during the sweep would lose its tag write
	a_no_input_in_clear: assert property (@(posedge clk) disable iff (reset)
		clear_busy |-> !st0_valid);
	a_valids_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown({st0_valid, st1_valid, st2_valid, mode}));

endmodule

`default_nettype wire

//--- logic/output_skid_buffer.sv
// ------------------------------------------------------------
// output skid buffer
// registered output plus one skid slot, ready is registered
// ------------------------------------------------------------

`default_nettype none

module output_skid_buffer #(
	parameter int TAG_ADDR_WIDTH = 6,
	parameter int USER_WIDTH     = 4
) (
	input  logic                      clk,
	input  logic                      reset,
	tag_result_if.sink                res,
	output logic [USER_WIDTH-1:0]     m_user,
	output logic                      m_last,
	output logic                      m_border,
	output logic [TAG_ADDR_WIDTH-1:0] m_tag_addr,
	output tex_cache_pkg::pix_x_t     m_pix_addrx,
	output tex_cache_pkg::pix_y_t     m_pix_addry,
	output tex_cache_pkg::blk_x_t     m_blk_addrx,
	output tex_cache_pkg::blk_y_t     m_blk_addry,
	output logic                      m_cache_hit,
	output logic                      m_valid,
	input  logic                      m_ready
);
	import tex_cache_pkg::*;

	localparam int DATA_WIDTH = USER_WIDTH + 3 + TAG_ADDR_WIDTH + $bits(pix_x_t)
		+ $bits(pix_y_t) + $bits(blk_x_t) + $bits(blk_y_t);

	logic [DATA_WIDTH-1:0] in_data, out_data, skid_data;
	logic                  skid_valid;
	logic                  out_load;

	assign in_data = {res.user, res.last, res.border, res.tag_addr, res.pix_x, res.pix_y,
		res.blk_x, res.blk_y, res.hit};
	assign {m_user, m_last, m_border, m_tag_addr, m_pix_addrx, m_pix_addry,
		m_blk_addrx, m_blk_addry, m_cache_hit} = out_data;

	// skid slot empty means room for one more
	assign res.ready = !skid_valid;
	assign out_load  = !m_valid || m_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			m_valid    <= 1'b0;
			skid_valid <= 1'b0;
		end else if (out_load) begin
			m_valid    <= skid_valid || res.valid;
			skid_valid <= 1'b0;
		end else if (res.valid && res.ready) begin
			skid_valid <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (out_load) begin
			out_data <= skid_valid ? skid_data : in_data;
		end else if (res.ready) begin
			skid_data <= in_data;
		end
	end

	a_hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		(m_valid && !m_ready) |=> (m_valid && $stable(out_data)));

endmodule

`default_nettype wire

//--- logic/tex_cache_tag_top.sv
// ------------------------------------------------------------
// texture cache tag stage, top level
// lookup pipeline feeding a registered output buffer
// ------------------------------------------------------------

`default_nettype none

module tex_cache_tag_top #(
	parameter int TAG_ADDR_WIDTH = 6,
	parameter int USER_WIDTH     = 4
) (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      clear_start,
	output logic                      clear_busy,
	input  logic [USER_WIDTH-1:0]     s_user,
	input  logic                      s_last,
	input  logic                      s_border,
	input  tex_cache_pkg::addr_x_t    s_addrx,
	input  tex_cache_pkg::addr_y_t    s_addry,
	input  logic                      s_valid,
	output logic                      s_ready,
	output logic [USER_WIDTH-1:0]     m_user,
	output logic                      m_last,
	output logic                      m_border,
	output logic [TAG_ADDR_WIDTH-1:0] m_tag_addr,
	output tex_cache_pkg::pix_x_t     m_pix_addrx,
	output tex_cache_pkg::pix_y_t     m_pix_addry,
	output tex_cache_pkg::blk_x_t     m_blk_addrx,
	output tex_cache_pkg::blk_y_t     m_blk_addry,
	output logic                      m_cache_hit,
	output logic                      m_valid,
	input  logic                      m_ready
);

	tag_result_if #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH), .USER_WIDTH(USER_WIDTH)) res_if ();

	tag_lookup_pipe #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH), .USER_WIDTH(USER_WIDTH))
	tag_lookup_pipe_i (
		.clk(clk), .reset(reset), .clear_start(clear_start), .clear_busy(clear_busy),
		.s_user(s_user), .s_last(s_last), .s_border(s_border), .s_addrx(s_addrx),
		.s_addry(s_addry), .s_valid(s_valid), .s_ready(s_ready), .res(res_if.source));

	output_skid_buffer #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH), .USER_WIDTH(USER_WIDTH))
	output_skid_buffer_i (
		.clk(clk), .reset(reset), .res(res_if.sink),
		.m_user(m_user), .m_last(m_last), .m_border(m_border), .m_tag_addr(m_tag_addr),
		.m_pix_addrx(m_pix_addrx), .m_pix_addry(m_pix_addry),
		.m_blk_addrx(m_blk_addrx), .m_blk_addry(m_blk_addry),
		.m_cache_hit(m_cache_hit), .m_valid(m_valid), .m_ready(m_ready));

endmodule

`default_nettype wire

//--- verif/tex_cache_tag_tb.sv
// ------------------------------------------------------------
// testbench for the texture cache tag stage
// table-driven accesses checked against a reference tag model
// ------------------------------------------------------------

`default_nettype none

module tex_cache_tag_tb;
	import tex_cache_pkg::*;

	localparam int TAG_ADDR_WIDTH = 6;
	localparam int USER_WIDTH     = 4;
	localparam int HALF           = TAG_ADDR_WIDTH / 2;
	localparam int ENTRIES        = 1 << TAG_ADDR_WIDTH;
	localparam logic [31:0] SEED  = 32'h57c1911c;

	typedef struct packed {
		logic                  clear;
		addr_x_t               x;
		addr_y_t               y;
		logic                  border;
		logic [USER_WIDTH-1:0] user;
		logic                  last;
	} row_t;

	typedef struct packed {
		blk_x_t                    bx;
		blk_y_t                    by;
		pix_x_t                    px;
		pix_y_t                    py;
		logic [TAG_ADDR_WIDTH-1:0] tag_addr;
		logic [USER_WIDTH-1:0]     user;
		logic                      last;
		logic                      border;
		logic                      hit;
	} result_t;

	logic                      clk;
	logic                      reset;
	logic                      clear_start;
	logic                      clear_busy;
	logic [USER_WIDTH-1:0]     s_user;
	logic                      s_last;
	logic                      s_border;
	addr_x_t                   s_addrx;
	addr_y_t                   s_addry;
	logic                      s_valid;
	logic                      s_ready;
	logic [USER_WIDTH-1:0]     m_user;
	logic                      m_last;
	logic                      m_border;
	logic [TAG_ADDR_WIDTH-1:0] m_tag_addr;
	pix_x_t                    m_pix_addrx;
	pix_y_t                    m_pix_addry;
	blk_x_t                    m_blk_addrx;
	blk_y_t                    m_blk_addry;
	logic                      m_cache_hit;
	logic                      m_valid;
	logic                      m_ready;

	row_t    rows[$];
	result_t expect_q[$];
	result_t held;
	logic    hold_pending;
	logic    tag_valid [ENTRIES];
	blk_x_t  tag_bx [ENTRIES];
	blk_y_t  tag_by [ENTRIES];
	logic [31:0] rng;
	logic [31:0] stall_rng;
	int      cycle_count;
	int      cycle_limit;
	int      busy_cycles;

	tex_cache_tag_top #(.TAG_ADDR_WIDTH(TAG_ADDR_WIDTH), .USER_WIDTH(USER_WIDTH))
	tex_cache_tag_top_i (
		.clk(clk), .reset(reset), .clear_start(clear_start), .clear_busy(clear_busy),
		.s_user(s_user), .s_last(s_last), .s_border(s_border), .s_addrx(s_addrx),
		.s_addry(s_addry), .s_valid(s_valid), .s_ready(s_ready),
		.m_user(m_user), .m_last(m_last), .m_border(m_border), .m_tag_addr(m_tag_addr),
		.m_pix_addrx(m_pix_addrx), .m_pix_addry(m_pix_addry),
		.m_blk_addrx(m_blk_addrx), .m_blk_addry(m_blk_addry),
		.m_cache_hit(m_cache_hit), .m_valid(m_valid), .m_ready(m_ready));

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// low index half from x, high half from y folded with the next x bits
	function automatic logic [TAG_ADDR_WIDTH-1:0] expected_index(input blk_x_t bx,
		input blk_y_t by);
		logic [TAG_ADDR_WIDTH-1:0] idx;
		for (int i = 0; i < HALF; i++) begin
			idx[i]        = bx[i];
			idx[HALF + i] = by[i] ^ bx[HALF + i];
		end
		return idx;
	endfunction

	function automatic result_t read_outputs();
		result_t r;
		r.bx       = m_blk_addrx;
		r.by       = m_blk_addry;
		r.px       = m_pix_addrx;
		r.py       = m_pix_addry;
		r.tag_addr = m_tag_addr;
		r.user     = m_user;
		r.last     = m_last;
		r.border   = m_border;
		r.hit      = m_cache_hit;
		return r;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1);
	endtask

	// ------------------------------------------------------------
	// compare tasks

	task automatic check_coord(input string name, input blk_x_t got, input blk_x_t exp);
		if (got !== exp) stop_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_tag_addr(input string name, input logic [TAG_ADDR_WIDTH-1:0] got,
		input logic [TAG_ADDR_WIDTH-1:0] exp);
		if (got !== exp) stop_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) stop_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_user(input string name, input logic [USER_WIDTH-1:0] got,
		input logic [USER_WIDTH-1:0] exp);
		if (got !== exp) stop_run($sformatf("ERROR %s got %h expected %h", name, got, exp));
	endtask

	task automatic compare_result(input string sfx, input result_t got, input result_t exp);
		check_coord({"m_blk_addrx", sfx}, got.bx, exp.bx);
		check_coord({"m_blk_addry", sfx}, blk_x_t'(got.by), blk_x_t'(exp.by));
		check_coord({"m_pix_addrx", sfx}, blk_x_t'(got.px), blk_x_t'(exp.px));
		check_coord({"m_pix_addry", sfx}, blk_x_t'(got.py), blk_x_t'(exp.py));
		check_tag_addr({"m_tag_addr", sfx}, got.tag_addr, exp.tag_addr);
		check_user({"m_user", sfx}, got.user, exp.user);
		check_flag({"m_last", sfx}, got.last, exp.last);
		check_flag({"m_border", sfx}, got.border, exp.border);
		check_flag({"m_cache_hit", sfx}, got.hit, exp.hit);
	endtask

	// ------------------------------------------------------------
	// table building and drivers

	task automatic add_access(input addr_x_t x, input addr_y_t y, input logic border,
		input logic [USER_WIDTH-1:0] user, input logic last);
		rows.push_back('{clear: 1'b0, x: x, y: y, border: border, user: user, last: last});
	endtask

	task automatic add_clear();
		rows.push_back('{clear: 1'b1, x: '0, y: '0, border: 1'b0, user: '0, last: 1'b0});
	endtask

	task automatic send_access(input row_t r);
		result_t e;
		e.bx       = r.x[ADDR_X_WIDTH-1:BLK_X_SIZE];
		e.by       = r.y[ADDR_Y_WIDTH-1:BLK_Y_SIZE];
		e.px       = r.x[BLK_X_SIZE-1:0];
		e.py       = r.y[BLK_Y_SIZE-1:0];
		e.tag_addr = expected_index(e.bx, e.by);
		e.user     = r.user;
		e.last     = r.last;
		e.border   = r.border;
		{s_addrx, s_addry, s_border, s_user, s_last} = {r.x, r.y, r.border, r.user, r.last};
		s_valid = 1'b1;
		do @(negedge clk); while (!s_ready);
		// taken on the coming edge, so the model steps now
		e.hit = tag_valid[e.tag_addr] && tag_bx[e.tag_addr] == e.bx
			&& tag_by[e.tag_addr] == e.by;
		if (!r.border) begin
			tag_valid[e.tag_addr] = 1'b1;
			tag_bx[e.tag_addr]    = e.bx;
			tag_by[e.tag_addr]    = e.by;
		end
		expect_q.push_back(e);
		@(posedge clk);
		#1;
		s_valid = 1'b0;
	endtask

	task automatic run_clear();
		clear_start = 1'b1;
		do @(negedge clk); while (!clear_busy);
		for (int i = 0; i < ENTRIES; i++) tag_valid[i] = 1'b0;
		@(posedge clk);
		#1;
		clear_start = 1'b0;
	endtask

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		int n_clear;
		n_clear = 0;
		{reset, clear_start, s_valid, s_user, s_last, s_border} = '0;
		{s_addrx, s_addry, m_ready} = '0;
		reset = 1'b1;
		for (int i = 0; i < ENTRIES; i++) tag_valid[i] = 1'b0;
		// block A at (1,2), B at (1,10) shares its index, C at (2,2) does not
		add_access(12'h005, 12'h009, 1'b0, 4'h1, 1'b0);
		add_access(12'h006, 12'h00a, 1'b0, 4'h2, 1'b1);
		add_access(12'hfff, 12'habc, 1'b0, 4'h3, 1'b0);
		add_access(12'h004, 12'h028, 1'b0, 4'h4, 1'b0);
		add_access(12'h007, 12'h00b, 1'b0, 4'h5, 1'b0);
		add_access(12'h004, 12'h029, 1'b0, 4'h6, 1'b1);
		add_access(12'h005, 12'h008, 1'b0, 4'h7, 1'b0);
		add_access(12'h008, 12'h008, 1'b0, 4'h8, 1'b0);
		add_access(12'h005, 12'h009, 1'b0, 4'h9, 1'b0);
		add_access(12'h009, 12'h00b, 1'b0, 4'ha, 1'b1);
		// border lookups leave the entries alone
		add_access(12'h004, 12'h028, 1'b1, 4'hb, 1'b0);
		add_access(12'h005, 12'h009, 1'b0, 4'hc, 1'b0);
		add_access(12'h005, 12'h009, 1'b1, 4'hd, 1'b0);
		add_access(12'h100, 12'h040, 1'b1, 4'he, 1'b0);
		add_access(12'h100, 12'h040, 1'b0, 4'hf, 1'b0);
		add_access(12'h101, 12'h041, 1'b0, 4'h0, 1'b1);
		add_clear();
		add_access(12'h005, 12'h009, 1'b0, 4'h1, 1'b0);
		add_access(12'h008, 12'h008, 1'b0, 4'h2, 1'b0);
		add_access(12'h005, 12'h009, 1'b0, 4'h3, 1'b1);
		rng = SEED;
		stall_rng = SEED;
		for (int i = 0; i < 240; i++) begin
			rng = lcg(rng);
			if (i == 120) add_clear();
			add_access({6'h0, rng[30:25]}, {6'h0, rng[24:19]}, rng[18:16] == 3'd0,
				rng[15:12], rng[11]);
		end
		foreach (rows[i]) if (rows[i].clear) n_clear++;
		cycle_limit = 40 * rows.size() + n_clear * ENTRIES;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		foreach (rows[i]) begin
			if (rows[i].clear) run_clear();
			else send_access(rows[i]);
		end
		while (expect_q.size() != 0) @(posedge clk);
		repeat (20) @(posedge clk);
		$display("TB PASSED");
		$finish;
	end

	// random stalls on the output side
	initial begin
		forever begin
			@(posedge clk);
			#1;
			stall_rng = lcg(stall_rng);
			m_ready = stall_rng[31:30] != 2'b00;
		end
	end

	// ------------------------------------------------------------
	// output monitor, sampled mid-cycle

	always @(negedge clk) begin
		result_t got;
		got = read_outputs();
		if (!reset) begin
			if (clear_busy) begin
				busy_cycles++;
				if (s_ready) stop_run("input was offered ready while the clear sweep ran");
			end else if (busy_cycles != 0) begin
				if (busy_cycles < ENTRIES) stop_run("clear sweep ended before every entry");
				busy_cycles = 0;
			end
			if (hold_pending) begin
				check_flag("m_valid held", m_valid, 1'b1);
				compare_result(" held", got, held);
			end
			if (m_valid && m_ready) begin
				if (expect_q.size() == 0) stop_run("output transfer with no access pending");
				compare_result("", got, expect_q.pop_front());
			end
			hold_pending = m_valid && !m_ready;
			held = got;
		end
	end

	initial begin
		hold_pending = 1'b0;
		busy_cycles = 0;
		cycle_count = 0;
		@(posedge clk);
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		stop_run($sformatf("timeout after %0d cycles with %0d results still expected",
			cycle_count, expect_q.size()));
	end

endmodule

`default_nettype wire

//--- flist.f
logic/tex_cache_pkg.sv
logic/tag_result_if.sv
logic/tag_index_map.sv
logic/tag_ram.sv
logic/tag_lookup_pipe.sv
logic/output_skid_buffer.sv
logic/tex_cache_tag_top.sv
verif/tex_cache_tag_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the tag stage testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal -f flist.f \
	--top-module tex_cache_tag_tb -Mdir obj_dir -o tex_cache_tag_sim &&
./obj_dir/tex_cache_tag_sim | tee sim.log
grep -q "^TB PASSED$" sim.log && echo "simulation passed" ||
	{ echo "simulation failed"; exit 1; }
